/* sim.f */
source/kgp_risc_pkg.sv
source/alu.sv
source/instruction_decoder.sv
source/register_file.sv
source/branch_unit.sv
source/instruction_memory.sv
source/data_memory.sv
source/kgp_risc_core.sv
verification/kgp_risc_tb.sv

/* source/alu.sv */
module alu (
	input  logic [kgp_risc_pkg::data_width-1:0] a,
	input  logic [kgp_risc_pkg::data_width-1:0] b,
	input  logic [4:0]                          shift_amount,
	input  kgp_risc_pkg::alu_op_t               op,
	output logic [kgp_risc_pkg::data_width-1:0] result,
	output logic                                carry,
	output logic                                zero,
	output logic                                sign
);

	// One extra bit holds the carry out
	logic [kgp_risc_pkg::data_width:0] sum;
	logic [kgp_risc_pkg::data_width:0] negated;

	assign sum     = {1'b0, a} + {1'b0, b};
	assign negated = {1'b0, ~b} + 1'b1;

	always_comb begin
		result = a;
		carry  = 1'b0;
		case (op)
			kgp_risc_pkg::alu_add: begin
				result = sum[kgp_risc_pkg::data_width-1:0];
				carry  = sum[kgp_risc_pkg::data_width];
			end
			kgp_risc_pkg::alu_comp: begin
				result = negated[kgp_risc_pkg::data_width-1:0];
				carry  = negated[kgp_risc_pkg::data_width];
			end
			kgp_risc_pkg::alu_and: begin
				result = a & b;
			end
			kgp_risc_pkg::alu_xor: begin
				result = a ^ b;
			end
			kgp_risc_pkg::alu_shll: begin
				result = a << shift_amount;
			end
			kgp_risc_pkg::alu_shrl: begin
				result = a >> shift_amount;
			end
			kgp_risc_pkg::alu_shra: begin
				result = $signed(a) >>> shift_amount;
			end
			default: begin
				// Pass of a, used for the branch tests
				result = a;
			end
		endcase
	end

	assign zero = (result == '0);
	assign sign = result[kgp_risc_pkg::data_width-1];

	// Branch conditions rely on an untouched rs in pass mode
	always_comb begin
		assert final (op != kgp_risc_pkg::alu_pass || result == a)
			else $error("alu pass changed the operand");
	end

endmodule

/* source/branch_unit.sv */
module branch_unit (
	input  logic                                clk,
	input  logic                                rst_n,
	input  kgp_risc_pkg::branch_kind_t          kind,
	input  logic [15:0]                         imm,
	input  logic [25:0]                         target,
	input  logic [kgp_risc_pkg::data_width-1:0] rs_data,
	input  logic                                carry_in,
	input  logic                                zero,
	input  logic                                sign,
	input  logic                                flag_update,
	output logic [kgp_risc_pkg::data_width-1:0] pc,
	output logic [kgp_risc_pkg::data_width-1:0] link_pc,
	output logic                                halted
);

	logic                                carry_q;
	logic [kgp_risc_pkg::data_width-1:0] offset;
	logic [kgp_risc_pkg::data_width-1:0] relative_pc;
	logic [kgp_risc_pkg::data_width-1:0] jump_pc;
	logic [kgp_risc_pkg::data_width-1:0] next_pc;

	////////////////////////////////////////////////////////////
	// Candidate addresses
	////////////////////////////////////////////////////////////

	assign link_pc     = pc + 32'd4;
	assign offset      = {{(kgp_risc_pkg::data_width-18){imm[15]}}, imm, 2'b00};
	assign relative_pc = link_pc + offset;
	assign jump_pc     = {{(kgp_risc_pkg::data_width-28){1'b0}}, target, 2'b00};

	// Zero and sign come from the alu passing rs through
	always_comb begin
		case (kind)
			kgp_risc_pkg::br_jump,
			kgp_risc_pkg::br_link:    next_pc = jump_pc;
			kgp_risc_pkg::br_reg:     next_pc = rs_data;
			kgp_risc_pkg::br_ltz:     next_pc = sign ? relative_pc : link_pc;
			kgp_risc_pkg::br_zero:    next_pc = zero ? relative_pc : link_pc;
			kgp_risc_pkg::br_nonzero: next_pc = zero ? link_pc : relative_pc;
			kgp_risc_pkg::br_carry:   next_pc = carry_q ? relative_pc : link_pc;
			kgp_risc_pkg::br_nocarry: next_pc = carry_q ? link_pc : relative_pc;
			kgp_risc_pkg::br_halt:    next_pc = pc;
			default:                  next_pc = link_pc;
		endcase
	end

	////////////////////////////////////////////////////////////
	// State, frozen once halted
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc      <= '0;
			carry_q <= 1'b0;
			halted  <= 1'b0;
		end else if (!halted) begin
			pc <= next_pc;
			if (flag_update) begin
				carry_q <= carry_in;
			end
			if (kind == kgp_risc_pkg::br_halt) begin
				halted <= 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
		else $error("pc lost word alignment");

endmodule

/* source/data_memory.sv */
module data_memory (
	input  logic                                clk,
	input  logic [kgp_risc_pkg::data_width-1:0] address,
	input  logic                                write_en,
	input  logic [kgp_risc_pkg::data_width-1:0] write_data,
	output logic [kgp_risc_pkg::data_width-1:0] read_data
);

	logic [kgp_risc_pkg::data_width-1:0] words [kgp_risc_pkg::dmem_depth];

	logic [kgp_risc_pkg::mem_index_width-1:0] index;

	assign index = address[kgp_risc_pkg::mem_index_width+1:2];

	always_ff @(posedge clk) begin
		if (write_en) begin
			words[index] <= write_data;
		end
	end

	// Combinational read so lw finishes in its own cycle
	assign read_data = words[index];

	// Only whole words are stored, so a store needs an aligned address
	assert property (@(posedge clk) write_en |-> address[1:0] == 2'b00)
		else $error("unaligned store to %h", address);

endmodule

/* source/instruction_decoder.sv */
module instruction_decoder (
	input  kgp_risc_pkg::instr_t       instr,
	output logic                       reg_write,
	output logic                       mem_write,
	output logic                       mem_to_reg,
	output logic                       alu_source,
	output logic                       shift_source,
	output logic [1:0]                 dest_sel,
	output logic                       flag_update,
	output kgp_risc_pkg::alu_op_t      alu_op,
	output kgp_risc_pkg::branch_kind_t branch_kind
);

	always_comb begin
		// Defaults describe a no-op
		reg_write    = 1'b0;
		mem_write    = 1'b0;
		mem_to_reg   = 1'b0;
		alu_source   = 1'b0;
		shift_source = 1'b0;
		dest_sel     = kgp_risc_pkg::dest_rd;
		flag_update  = 1'b0;
		alu_op       = kgp_risc_pkg::alu_pass;
		branch_kind  = kgp_risc_pkg::br_none;

		case (instr.r.opcode)
			kgp_risc_pkg::op_rtype: begin
				reg_write = 1'b1;
				case (instr.r.func)
					kgp_risc_pkg::fn_add: begin
						alu_op      = kgp_risc_pkg::alu_add;
						flag_update = 1'b1;
					end
					kgp_risc_pkg::fn_comp:  alu_op = kgp_risc_pkg::alu_comp;
					kgp_risc_pkg::fn_and:   alu_op = kgp_risc_pkg::alu_and;
					kgp_risc_pkg::fn_xor:   alu_op = kgp_risc_pkg::alu_xor;
					kgp_risc_pkg::fn_shll:  alu_op = kgp_risc_pkg::alu_shll;
					kgp_risc_pkg::fn_shrl:  alu_op = kgp_risc_pkg::alu_shrl;
					kgp_risc_pkg::fn_shra:  alu_op = kgp_risc_pkg::alu_shra;
					kgp_risc_pkg::fn_shllv: begin
						alu_op       = kgp_risc_pkg::alu_shll;
						shift_source = 1'b1;
					end
					kgp_risc_pkg::fn_shrlv: begin
						alu_op       = kgp_risc_pkg::alu_shrl;
						shift_source = 1'b1;
					end
					kgp_risc_pkg::fn_shrav: begin
						alu_op       = kgp_risc_pkg::alu_shra;
						shift_source = 1'b1;
					end
					default: reg_write = 1'b0;
				endcase
			end
			kgp_risc_pkg::op_addi: begin
				reg_write   = 1'b1;
				dest_sel    = kgp_risc_pkg::dest_rt;
				alu_source  = 1'b1;
				alu_op      = kgp_risc_pkg::alu_add;
				flag_update = 1'b1;
			end
			kgp_risc_pkg::op_compi: begin
				reg_write  = 1'b1;
				dest_sel   = kgp_risc_pkg::dest_rt;
				alu_source = 1'b1;
				alu_op     = kgp_risc_pkg::alu_comp;
			end
			kgp_risc_pkg::op_lw: begin
				reg_write  = 1'b1;
				mem_to_reg = 1'b1;
				dest_sel   = kgp_risc_pkg::dest_rt;
				alu_source = 1'b1;
				alu_op     = kgp_risc_pkg::alu_add;
			end
			kgp_risc_pkg::op_sw: begin
				mem_write  = 1'b1;
				alu_source = 1'b1;
				alu_op     = kgp_risc_pkg::alu_add;
			end
			kgp_risc_pkg::op_b:  branch_kind = kgp_risc_pkg::br_jump;
			kgp_risc_pkg::op_bl: begin
				reg_write   = 1'b1;
				dest_sel    = kgp_risc_pkg::dest_link;
				branch_kind = kgp_risc_pkg::br_link;
			end
			kgp_risc_pkg::op_br:   branch_kind = kgp_risc_pkg::br_reg;
			kgp_risc_pkg::op_bltz: branch_kind = kgp_risc_pkg::br_ltz;
			kgp_risc_pkg::op_bz:   branch_kind = kgp_risc_pkg::br_zero;
			kgp_risc_pkg::op_bnz:  branch_kind = kgp_risc_pkg::br_nonzero;
			kgp_risc_pkg::op_bcy:  branch_kind = kgp_risc_pkg::br_carry;
			kgp_risc_pkg::op_bncy: branch_kind = kgp_risc_pkg::br_nocarry;
			kgp_risc_pkg::op_halt: branch_kind = kgp_risc_pkg::br_halt;
			default: ;
		endcase
	end

	always_comb begin
		assert final (!(mem_write && reg_write))
			else $error("decoder asserts register write and store together");
	end

endmodule

/* source/instruction_memory.sv */
module instruction_memory (
	input  logic                                clk,
	input  logic                                load_en,
	input  logic [kgp_risc_pkg::data_width-1:0] load_addr,
	input  logic [kgp_risc_pkg::data_width-1:0] load_data,
	input  logic [kgp_risc_pkg::data_width-1:0] pc,
	output logic [kgp_risc_pkg::data_width-1:0] instr
);

	logic [kgp_risc_pkg::data_width-1:0] words [kgp_risc_pkg::imem_depth];

	logic [kgp_risc_pkg::mem_index_width-1:0] load_index;
	logic [kgp_risc_pkg::mem_index_width-1:0] fetch_index;

	// Byte addresses, word granular
	assign load_index  = load_addr[kgp_risc_pkg::mem_index_width+1:2];
	assign fetch_index = pc[kgp_risc_pkg::mem_index_width+1:2];

	// Program load port, open in and out of reset
	always_ff @(posedge clk) begin
		if (load_en) begin
			words[load_index] <= load_data;
		end
	end

	assign instr = words[fetch_index];

endmodule

/* source/kgp_risc_core.sv */
module kgp_risc_core (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    load_en,
	input  logic [kgp_risc_pkg::data_width-1:0]     load_addr,
	input  logic [kgp_risc_pkg::data_width-1:0]     load_data,
	output logic [kgp_risc_pkg::data_width-1:0]     pc,
	output logic                                    rf_write_en,
	output logic [kgp_risc_pkg::reg_addr_width-1:0] rf_write_addr,
	output logic [kgp_risc_pkg::data_width-1:0]     rf_write_data,
	output logic                                    store_en,
	output logic [kgp_risc_pkg::data_width-1:0]     store_addr,
	output logic [kgp_risc_pkg::data_width-1:0]     store_data,
	output logic                                    halted
);

	kgp_risc_pkg::instr_t       instr;
	kgp_risc_pkg::alu_op_t      alu_op;
	kgp_risc_pkg::branch_kind_t branch_kind;

	logic       reg_write, mem_write, mem_to_reg;
	logic       alu_source, shift_source, flag_update;
	logic [1:0] dest_sel;
	logic       carry, zero, sign, active;
	logic [4:0] shift_amount;

	logic [kgp_risc_pkg::data_width-1:0] rs_data, rt_data, immediate, alu_b;
	logic [kgp_risc_pkg::data_width-1:0] result, read_data, link_pc;

	////////////////////////////////////////////////////////////
	// Operand and write-back muxes
	////////////////////////////////////////////////////////////

	assign immediate    = {{(kgp_risc_pkg::data_width-16){instr.i.imm[15]}}, instr.i.imm};
	assign alu_b        = alu_source ? immediate : rt_data;
	assign shift_amount = shift_source ? rt_data[4:0] : instr.r.shamt;

	always_comb begin
		case (dest_sel)
			kgp_risc_pkg::dest_rt:   rf_write_addr = instr.r.rt;
			kgp_risc_pkg::dest_link: rf_write_addr = kgp_risc_pkg::link_reg;
			default:                 rf_write_addr = instr.r.rd;
		endcase
	end

	assign rf_write_data = (dest_sel == kgp_risc_pkg::dest_link) ? link_pc :
	                       mem_to_reg ? read_data : result;

	// Nothing commits in reset or after halt
	assign active      = rst_n & ~halted;
	assign rf_write_en = reg_write & active;
	assign store_en    = mem_write & active;
	assign store_addr  = result;
	assign store_data  = rt_data;

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////

	instruction_memory i_instruction_memory (.clk(clk), .load_en(load_en),
		.load_addr(load_addr), .load_data(load_data), .pc(pc), .instr(instr));

	instruction_decoder i_instruction_decoder (.instr(instr), .reg_write(reg_write),
		.mem_write(mem_write), .mem_to_reg(mem_to_reg), .alu_source(alu_source),
		.shift_source(shift_source), .dest_sel(dest_sel), .flag_update(flag_update),
		.alu_op(alu_op), .branch_kind(branch_kind));

	register_file i_register_file (.clk(clk), .rst_n(rst_n), .rs_addr(instr.r.rs),
		.rt_addr(instr.r.rt), .write_en(rf_write_en), .write_addr(rf_write_addr),
		.write_data(rf_write_data), .rs_data(rs_data), .rt_data(rt_data));

	alu i_alu (.a(rs_data), .b(alu_b), .shift_amount(shift_amount), .op(alu_op),
		.result(result), .carry(carry), .zero(zero), .sign(sign));

	data_memory i_data_memory (.clk(clk), .address(result), .write_en(store_en),
		.write_data(rt_data), .read_data(read_data));

	branch_unit i_branch_unit (.clk(clk), .rst_n(rst_n), .kind(branch_kind),
		.imm(instr.i.imm), .target(instr.j.target), .rs_data(rs_data),
		.carry_in(carry), .zero(zero), .sign(sign), .flag_update(flag_update),
		.pc(pc), .link_pc(link_pc), .halted(halted));

endmodule

/* source/kgp_risc_pkg.sv */
package kgp_risc_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////

	localparam int data_width      = 32;
	localparam int reg_addr_width  = 5;
	localparam int imem_depth      = 256;
	localparam int dmem_depth      = 256;
	localparam int mem_index_width = 8;

	// Return address register for bl
	localparam logic [reg_addr_width-1:0] link_reg = 5'd31;

	// Write address select
	localparam logic [1:0] dest_rd   = 2'd0;
	localparam logic [1:0] dest_rt   = 2'd1;
	localparam logic [1:0] dest_link = 2'd2;

	////////////////////////////////////////////////////////////
	// Opcodes and function codes
	////////////////////////////////////////////////////////////

	localparam logic [5:0] op_rtype = 6'd0;
	localparam logic [5:0] op_addi  = 6'd1;
	localparam logic [5:0] op_compi = 6'd2;
	localparam logic [5:0] op_lw    = 6'd3;
	localparam logic [5:0] op_sw    = 6'd4;
	localparam logic [5:0] op_b     = 6'd5;
	localparam logic [5:0] op_bl    = 6'd6;
	localparam logic [5:0] op_br    = 6'd7;
	localparam logic [5:0] op_bltz  = 6'd8;
	localparam logic [5:0] op_bz    = 6'd9;
	localparam logic [5:0] op_bnz   = 6'd10;
	localparam logic [5:0] op_bcy   = 6'd11;
	localparam logic [5:0] op_bncy  = 6'd12;
	localparam logic [5:0] op_halt  = 6'd63;

	localparam logic [5:0] fn_add   = 6'd0;
	localparam logic [5:0] fn_comp  = 6'd1;
	localparam logic [5:0] fn_and   = 6'd2;
	localparam logic [5:0] fn_xor   = 6'd3;
	localparam logic [5:0] fn_shll  = 6'd4;
	localparam logic [5:0] fn_shrl  = 6'd5;
	localparam logic [5:0] fn_shra  = 6'd6;
	localparam logic [5:0] fn_shllv = 6'd7;
	localparam logic [5:0] fn_shrlv = 6'd8;
	localparam logic [5:0] fn_shrav = 6'd9;

	typedef enum logic [3:0] {
		alu_add, alu_comp, alu_and, alu_xor,
		alu_shll, alu_shrl, alu_shra, alu_pass
	} alu_op_t;

	typedef enum logic [3:0] {
		br_none, br_jump, br_link, br_reg,
		br_ltz, br_zero, br_nonzero,
		br_carry, br_nocarry,
		br_halt
	} branch_kind_t;

	// One instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] func;
		} r;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
		struct packed {
			logic [5:0]  opcode;
			logic [25:0] target;
		} j;
	} instr_t;

endpackage

/* source/register_file.sv */
module register_file (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic [kgp_risc_pkg::reg_addr_width-1:0] rs_addr,
	input  logic [kgp_risc_pkg::reg_addr_width-1:0] rt_addr,
	input  logic                                    write_en,
	input  logic [kgp_risc_pkg::reg_addr_width-1:0] write_addr,
	input  logic [kgp_risc_pkg::data_width-1:0]     write_data,
	output logic [kgp_risc_pkg::data_width-1:0]     rs_data,
	output logic [kgp_risc_pkg::data_width-1:0]     rt_data
);

	localparam int reg_count = 2 ** kgp_risc_pkg::reg_addr_width;

	logic [kgp_risc_pkg::data_width-1:0] registers [reg_count];

	// All registers clear on reset, r0 included
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int idx = 0; idx < reg_count; idx++) begin
				registers[idx] <= '0;
			end
		end else if (write_en) begin
			registers[write_addr] <= write_data;
		end
	end

	// Read ports see the old value during a write
	assign rs_data = registers[rs_addr];
	assign rt_data = registers[rt_addr];

endmodule

/* verification/kgp_risc_tb.sv */
module kgp_risc_tb;

	logic                                    clk;
	logic                                    rst_n;
	logic                                    load_en;
	logic [kgp_risc_pkg::data_width-1:0]     load_addr;
	logic [kgp_risc_pkg::data_width-1:0]     load_data;
	logic [kgp_risc_pkg::data_width-1:0]     pc;
	logic                                    rf_write_en;
	logic [kgp_risc_pkg::reg_addr_width-1:0] rf_write_addr;
	logic [kgp_risc_pkg::data_width-1:0]     rf_write_data;
	logic                                    store_en;
	logic [kgp_risc_pkg::data_width-1:0]     store_addr;
	logic [kgp_risc_pkg::data_width-1:0]     store_data;
	logic                                    halted;

	// Contents of the vectors file
	logic [31:0] prog_addr [$];
	logic [31:0] prog_word [$];
	byte         exp_kind [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_value [$];
	logic [31:0] halt_pc;

	int   next_entry;
	int   error_count;
	int   tests_passed;
	int   tests_failed;
	logic beyond_list;

	kgp_risc_core i_kgp_risc_core (.clk(clk), .rst_n(rst_n), .load_en(load_en),
		.load_addr(load_addr), .load_data(load_data), .pc(pc), .rf_write_en(rf_write_en),
		.rf_write_addr(rf_write_addr), .rf_write_data(rf_write_data), .store_en(store_en),
		.store_addr(store_addr), .store_data(store_data), .halted(halted));

	always #50 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected)
			else begin
				$display("[ERROR] time %0t %s expected %h got %h", $time, name, expected, got);
				error_count++;
			end
	endtask

	task automatic close_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic read_vectors(output bit opened);
		int                fd;
		int                fields;
		int                fields_needed;
		byte               tag;
		logic [31:0]       first;
		logic [31:0]       second;
		logic [8*128-1:0]  rest;
		fd = $fopen("verification/kgp_risc_vectors.txt", "r");
		opened = (fd != 0);
		if (opened) begin
			while ($fscanf(fd, " %c", tag) == 1) begin
				fields_needed = 0;
				case (tag)
					"P": begin
						fields_needed = 2;
						fields = $fscanf(fd, "%h %h", first, second);
						prog_addr.push_back(first);
						prog_word.push_back(second);
					end
					"R", "M": begin
						fields_needed = 2;
						fields = $fscanf(fd, "%h %h", first, second);
						exp_kind.push_back(tag);
						exp_addr.push_back(first);
						exp_value.push_back(second);
					end
					"H": begin
						fields_needed = 1;
						fields = $fscanf(fd, "%h", halt_pc);
					end
					// Rest of a comment line
					default: fields = $fgets(rest, fd);
				endcase
				assert (fields >= fields_needed)
					else begin
						$display("Malformed %c line in the vectors file", tag);
						error_count++;
					end
			end
			$fclose(fd);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Trace checker with one entry per retiring write
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (rf_write_en || store_en) begin
			beyond_list = (next_entry >= exp_kind.size());
			assert (!beyond_list)
				else begin
					$display("Unexpected write at time %0t after the last listed entry", $time);
					error_count++;
				end
			if (!beyond_list) begin
				assert ((exp_kind[next_entry] == "R") == rf_write_en)
					else begin
						$display("Write of the wrong kind at time %0t for entry %0d",
							$time, next_entry);
						error_count++;
					end
				if (rf_write_en) begin
					check_value("rf_write_addr", {27'b0, rf_write_addr}, exp_addr[next_entry]);
					check_value("rf_write_data", rf_write_data, exp_value[next_entry]);
				end else begin
					check_value("store_addr", store_addr, exp_addr[next_entry]);
					check_value("store_data", store_data, exp_value[next_entry]);
				end
			end
			next_entry++;
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		bit opened;
		int cycles;
		int errors_before;
		clk = 1'b0;
		rst_n = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		next_entry = 0;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		halt_pc = '0;

		read_vectors(opened);
		assert (opened)
			else begin
				$display("Could not open the vectors file");
				error_count++;
			end
		close_test("vectors file", 0);

		if (opened) begin
			// One program word per cycle and then eight more cycles of reset
			foreach (prog_addr[idx]) begin
				@(negedge clk);
				load_en = 1'b1;
				load_addr = prog_addr[idx];
				load_data = prog_word[idx];
			end
			@(negedge clk);
			load_en = 1'b0;
			repeat (8) @(negedge clk);
			rst_n = 1'b1;

			errors_before = error_count;
			cycles = 0;
			while (!halted && cycles < 2000) begin
				@(negedge clk);
				cycles++;
			end
			close_test("register and store trace", errors_before);

			errors_before = error_count;
			assert (halted)
				else begin
					$display("Core did not halt within 2000 cycles");
					error_count++;
				end
			if (halted) begin
				check_value("pc", pc, halt_pc);
				// Any write now reaches the trace checker as an extra entry
				repeat (4) @(negedge clk);
				check_value("pc", pc, halt_pc);
			end
			close_test("halt", errors_before);

			errors_before = error_count;
			assert (next_entry == exp_kind.size())
				else begin
					$display("Core made %0d writes but the vectors file lists %0d",
						next_entry, exp_kind.size());
					error_count++;
				end
			close_test("write count", errors_before);
		end

		$display("tests passed %0d, tests failed %0d, errors %0d",
			tests_passed, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* verification/kgp_risc_vectors.txt */
# P byte_address instruction_word | R register value | M byte_address value | H halt_pc
# All numbers in hex; R and M lines are listed in retirement order
P 00000000 04010005
P 00000004 08020003
P 00000008 00221800
P 0000000C 2C000001
P 00000010 04090099
P 00000014 00012001
P 00000018 00413002
P 0000001C 00413803
P 00000020 00204104
P 00000024 00805705
P 00000028 00805846
P 0000002C 00236007
P 00000030 00E36808
P 00000034 00E37009
P 00000038 10070040
P 0000003C 0C2F003B
P 00000040 24000001
P 00000044 04090099
P 00000048 24200001
P 0000004C 28200001
P 00000050 04090099
P 00000054 28000001
P 00000058 20800001
P 0000005C 04090099
P 00000060 20200001
P 00000064 30000001
P 00000068 04100001
P 0000006C 2C000001
P 00000070 30000001
P 00000074 04090099
P 00000078 18000020
P 0000007C 14000022
P 00000080 04110011
P 00000084 1FE00000
P 00000088 FC000000
R 01 00000005
R 02 FFFFFFFD
R 03 00000002
R 04 FFFFFFFB
R 06 00000005
R 07 FFFFFFF8
R 08 00000050
R 0A 0000000F
R 0B FFFFFFFD
R 0C 00000014
R 0D 3FFFFFFE
R 0E FFFFFFFE
M 00000040 FFFFFFF8
R 0F FFFFFFF8
R 10 00000001
R 1F 0000007C
R 11 00000011
H 00000088
